// ==== design/soc_mem_pkg.sv ====
/*
 * Widths, address map and halfword timing shared by the memory subsystem.
 * Latencies count clocks per halfword phase and must cover the parts' access time.
 * LAT_CNT_W is sized from FLASH_LATENCY, which is assumed to be the longer one.
 */
package soc_mem_pkg;

	// --------------------------------------------------
	// Bus and board widths
	// --------------------------------------------------
	localparam int WB_ADR_W    = 32;
	localparam int WB_DAT_W    = 32;
	localparam int WB_SEL_W    = 4;
	localparam int MEM_ADR_W   = 26;
	localparam int MEM_DAT_W   = 16;
	// Halfword address widths of the two parts
	localparam int SRAM_ADR_W  = 23;
	localparam int FLASH_ADR_W = 24;
	// Byte address inside block RAM, 1024 words
	localparam int BRAM_ADR_W  = 12;

	// --------------------------------------------------
	// Address map
	// --------------------------------------------------
	localparam logic [2:0]  SRAM_REGION  = 3'h4;
	localparam logic [2:0]  FLASH_REGION = 3'h5;
	localparam logic [14:0] BRAM_REGION  = 15'h0000;

	// Clocks per halfword phase
	localparam int SRAM_LATENCY  = 5;
	localparam int FLASH_LATENCY = 8;
	localparam int LAT_CNT_W     = $clog2(FLASH_LATENCY + 1);

	typedef enum logic [1:0] {SLV_NONE, SLV_BRAM, SLV_SRAM, SLV_FLASH} slave_sel_t;

	// Phase sequence of both halfword controllers
	typedef enum logic [1:0] {PH_IDLE, PH_HI, PH_LO, PH_ACK} mem_phase_t;

endpackage

// ==== design/wb_addr_decode.sv ====
`timescale 1ns/1ps
/*
 * Single master address decoder, purely combinational routing.
 * Unmapped accesses get a one-cycle ack with zero data.
 */
module wb_addr_decode import soc_mem_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [WB_DAT_W-1:0] bram_dat_i,
	input  logic [WB_DAT_W-1:0] sram_dat_i,
	input  logic [WB_DAT_W-1:0] flash_dat_i,
	input  logic                bram_ack_i,
	input  logic                sram_ack_i,
	input  logic                flash_ack_i,
	output logic                bram_cyc_o,
	output logic                bram_stb_o,
	output logic                sram_cyc_o,
	output logic                sram_stb_o,
	output logic                flash_cyc_o,
	output logic                flash_stb_o,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	output logic                wb_ack_o
);
	slave_sel_t slv;
	logic       req;
	logic       none_ack;

	assign req = wb_cyc_i && wb_stb_i;

	// Wide regions first, block RAM owns the low 128K
	always_comb begin
		if (wb_adr_i[WB_ADR_W-1 -: 3] == SRAM_REGION)
			slv = SLV_SRAM;
		else if (wb_adr_i[WB_ADR_W-1 -: 3] == FLASH_REGION)
			slv = SLV_FLASH;
		else if (wb_adr_i[WB_ADR_W-1 -: 15] == BRAM_REGION)
			slv = SLV_BRAM;
		else
			slv = SLV_NONE;
	end

	assign bram_cyc_o  = wb_cyc_i && (slv == SLV_BRAM);
	assign bram_stb_o  = req && (slv == SLV_BRAM);
	assign sram_cyc_o  = wb_cyc_i && (slv == SLV_SRAM);
	assign sram_stb_o  = req && (slv == SLV_SRAM);
	assign flash_cyc_o = wb_cyc_i && (slv == SLV_FLASH);
	assign flash_stb_o = req && (slv == SLV_FLASH);

	// Local ack for holes in the map
	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			none_ack <= 1'b0;
		else
			none_ack <= req && (slv == SLV_NONE) && !none_ack;
	end

	// Return path follows the held address
	always_comb begin
		case (slv)
			SLV_BRAM: begin
				wb_dat_o = bram_dat_i;
				wb_ack_o = bram_ack_i;
			end
			SLV_SRAM: begin
				wb_dat_o = sram_dat_i;
				wb_ack_o = sram_ack_i;
			end
			SLV_FLASH: begin
				wb_dat_o = flash_dat_i;
				wb_ack_o = flash_ack_i;
			end
			default: begin
				wb_dat_o = '0;
				wb_ack_o = none_ack;
			end
		endcase
	end

	a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({bram_stb_o, sram_stb_o, flash_stb_o}));
	// Every target must end its ack after one cycle
	a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_ack_o |=> !wb_ack_o);

endmodule

// ==== design/wb_bram.sv ====
`timescale 1ns/1ps
/*
 * On-chip word RAM, contents undefined until written.
 * Upper address bits alias; only BRAM_ADR_W byte address bits are decoded.
 */
module wb_bram import soc_mem_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  cyc_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  logic [BRAM_ADR_W-1:0] adr_i,
	input  logic [WB_SEL_W-1:0]   sel_i,
	input  logic [WB_DAT_W-1:0]   dat_i,
	output logic [WB_DAT_W-1:0]   dat_o,
	output logic                  ack_o
);
	logic [WB_DAT_W-1:0]   mem [2**(BRAM_ADR_W-2)];
	logic [BRAM_ADR_W-3:0] word_adr;

	assign word_adr = adr_i[BRAM_ADR_W-1:2];

	// Byte lane writes, read data registered every cycle
	always_ff @(posedge clk_i) begin
		if (cyc_i && stb_i && we_i && !ack_o) begin
			for (int b = 0; b < WB_SEL_W; b++) begin
				if (sel_i[b])
					mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
			end
		end
		dat_o <= mem[word_adr];
	end

	// One-cycle ack, blocked while the last one is up
	always_ff @(posedge clk_i) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= cyc_i && stb_i && !ack_o;
	end

endmodule

// ==== design/wb_sram16.sv ====
`timescale 1ns/1ps
/*
 * Async 16-bit SRAM controller, a bus word is two halfword phases, high half first.
 * WE stays low for each whole write phase; the part must accept the WE-low window.
 * Reads enable both byte lanes; sel_i only matters for writes.
 */
module wb_sram16 import soc_mem_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  cyc_i,
	input  logic                  stb_i,
	input  logic                  we_i,
	input  logic [WB_ADR_W-1:0]   adr_i,
	input  logic [WB_SEL_W-1:0]   sel_i,
	input  logic [WB_DAT_W-1:0]   dat_i,
	input  logic [MEM_DAT_W-1:0]  mem_d_i,
	output logic [WB_DAT_W-1:0]   dat_o,
	output logic                  ack_o,
	output logic [SRAM_ADR_W-1:0] sram_adr_o,
	output logic [MEM_DAT_W-1:0]  sram_d_o,
	output logic                  sram_d_oe_o,
	output logic                  sram_oe_n_o,
	output logic                  sram_we_n_o,
	output logic [1:0]            sram_be_n_o,
	output logic                  sram_ce_n_o
);
	mem_phase_t           state;
	logic [LAT_CNT_W-1:0] wait_cnt;
	logic                 busy;
	logic                 lo_half;
	logic                 phase_done;

	assign busy       = (state == PH_HI) || (state == PH_LO);
	assign lo_half    = (state == PH_LO);
	assign phase_done = (wait_cnt == '0);

	// --------------------------------------------------
	// Phase FSM
	// --------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state    <= PH_IDLE;
			wait_cnt <= '0;
			ack_o    <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			case (state)
				PH_IDLE: if (cyc_i && stb_i) begin
					state    <= PH_HI;
					wait_cnt <= LAT_CNT_W'(SRAM_LATENCY - 1);
				end
				PH_HI: if (phase_done) begin
					state    <= PH_LO;
					wait_cnt <= LAT_CNT_W'(SRAM_LATENCY - 1);
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
				PH_LO: if (phase_done) begin
					state <= PH_ACK;
					ack_o <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
				// Master still holds stb here, skip it
				default: state <= PH_IDLE;
			endcase
		end
	end

	// Read halves sampled on the last clock of their phase
	always_ff @(posedge clk_i) begin
		if (busy && phase_done && !we_i) begin
			if (lo_half)
				dat_o[MEM_DAT_W-1:0] <= mem_d_i;
			else
				dat_o[WB_DAT_W-1:MEM_DAT_W] <= mem_d_i;
		end
	end

	// --------------------------------------------------
	// Pin drive, halfword 2W then 2W+1
	// --------------------------------------------------
	assign sram_adr_o  = {adr_i[SRAM_ADR_W:2], lo_half};
	assign sram_d_o    = lo_half ? dat_i[MEM_DAT_W-1:0] : dat_i[WB_DAT_W-1:MEM_DAT_W];
	assign sram_d_oe_o = busy && we_i;
	assign sram_we_n_o = !(busy && we_i);
	assign sram_oe_n_o = !(busy && !we_i);
	assign sram_ce_n_o = !busy;
	// Low active lanes, upper selects go with the high half
	assign sram_be_n_o = !we_i   ? 2'b00 :
	                     lo_half ? ~sel_i[1:0] : ~sel_i[3:2];

	a_we_oe_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(!sram_we_n_o && !sram_oe_n_o));

endmodule

// ==== design/norflash16.sv ====
`timescale 1ns/1ps
/*
 * Read-only 16-bit NOR flash controller, high halfword first.
 * Writes get an immediate ack and never reach the pins.
 */
module norflash16 import soc_mem_pkg::*; (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   cyc_i,
	input  logic                   stb_i,
	input  logic                   we_i,
	input  logic [WB_ADR_W-1:0]    adr_i,
	input  logic [MEM_DAT_W-1:0]   mem_d_i,
	output logic [WB_DAT_W-1:0]    dat_o,
	output logic                   ack_o,
	output logic [FLASH_ADR_W-1:0] flash_adr_o,
	output logic                   flash_oe_n_o,
	output logic                   flash_ce_n_o
);
	mem_phase_t           state;
	logic [LAT_CNT_W-1:0] wait_cnt;
	logic                 busy;
	logic                 lo_half;
	logic                 phase_done;

	assign busy       = (state == PH_HI) || (state == PH_LO);
	assign lo_half    = (state == PH_LO);
	assign phase_done = (wait_cnt == '0);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state    <= PH_IDLE;
			wait_cnt <= '0;
			ack_o    <= 1'b0;
		end else begin
			ack_o <= 1'b0;
			case (state)
				PH_IDLE: if (cyc_i && stb_i) begin
					if (we_i) begin
						// Program cycles unsupported, swallow it
						state <= PH_ACK;
						ack_o <= 1'b1;
					end else begin
						state    <= PH_HI;
						wait_cnt <= LAT_CNT_W'(FLASH_LATENCY - 1);
					end
				end
				PH_HI: if (phase_done) begin
					state    <= PH_LO;
					wait_cnt <= LAT_CNT_W'(FLASH_LATENCY - 1);
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
				PH_LO: if (phase_done) begin
					state <= PH_ACK;
					ack_o <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
				default: state <= PH_IDLE;
			endcase
		end
	end

	// Assemble the word at the end of each phase
	always_ff @(posedge clk_i) begin
		if (busy && phase_done) begin
			if (lo_half)
				dat_o[MEM_DAT_W-1:0] <= mem_d_i;
			else
				dat_o[WB_DAT_W-1:MEM_DAT_W] <= mem_d_i;
		end
	end

	assign flash_adr_o  = {adr_i[FLASH_ADR_W:2], lo_half};
	assign flash_oe_n_o = !busy;
	assign flash_ce_n_o = !busy;

endmodule

// ==== design/mem_pin_select.sv ====
`timescale 1ns/1ps
/*
 * Board pin sharing between SRAM and flash, selected by chip enable.
 * SRAM wins if both are low, which the controllers never allow.
 */
module mem_pin_select import soc_mem_pkg::*; (
	input  logic [SRAM_ADR_W-1:0]  sram_adr_i,
	input  logic [MEM_DAT_W-1:0]   sram_d_i,
	input  logic                   sram_d_oe_i,
	input  logic                   sram_oe_n_i,
	input  logic                   sram_we_n_i,
	input  logic [1:0]             sram_be_n_i,
	input  logic                   sram_ce_n_i,
	input  logic [FLASH_ADR_W-1:0] flash_adr_i,
	input  logic                   flash_oe_n_i,
	input  logic                   flash_ce_n_i,
	output logic [MEM_ADR_W-1:0]   mem_adr_o,
	output logic [MEM_DAT_W-1:0]   mem_d_o,
	output logic                   mem_d_oe_o,
	output logic                   mem_oe_n_o,
	output logic                   mem_we_n_o,
	output logic                   sram_ub_n_o,
	output logic                   sram_lb_n_o
);
	always_comb begin
		// Idle pins unless a part is selected
		mem_adr_o   = '0;
		mem_d_o     = '0;
		mem_d_oe_o  = 1'b0;
		mem_oe_n_o  = 1'b1;
		mem_we_n_o  = 1'b1;
		sram_ub_n_o = 1'b1;
		sram_lb_n_o = 1'b1;
		if (!sram_ce_n_i) begin
			mem_adr_o   = {{(MEM_ADR_W-SRAM_ADR_W){1'b0}}, sram_adr_i};
			mem_d_o     = sram_d_i;
			mem_d_oe_o  = sram_d_oe_i;
			mem_oe_n_o  = sram_oe_n_i;
			mem_we_n_o  = sram_we_n_i;
			sram_ub_n_o = sram_be_n_i[1];
			sram_lb_n_o = sram_be_n_i[0];
		end else if (!flash_ce_n_i) begin
			// Flash is read only, data bus stays released
			mem_adr_o  = {{(MEM_ADR_W-FLASH_ADR_W){1'b0}}, flash_adr_i};
			mem_oe_n_o = flash_oe_n_i;
		end
	end

	// Both controllers idle outside their own access
	always_comb begin
		a_ce_excl: assert (sram_ce_n_i || flash_ce_n_i)
			else $error("SRAM and flash selected together");
	end

endmodule

// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps
/*
 * Memory subsystem top, one bus master, three targets.
 * Board data bus split into in, out and enable; tristate lives outside.
 */
module mem_subsystem import soc_mem_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [WB_ADR_W-1:0]  wb_adr_i,
	input  logic [WB_SEL_W-1:0]  wb_sel_i,
	input  logic [WB_DAT_W-1:0]  wb_dat_i,
	output logic [WB_DAT_W-1:0]  wb_dat_o,
	output logic                 wb_ack_o,
	output logic [MEM_ADR_W-1:0] mem_adr_o,
	input  logic [MEM_DAT_W-1:0] mem_d_i,
	output logic [MEM_DAT_W-1:0] mem_d_o,
	output logic                 mem_d_oe_o,
	output logic                 mem_oe_n_o,
	output logic                 mem_we_n_o,
	output logic                 sram_ce_n_o,
	output logic                 sram_ub_n_o,
	output logic                 sram_lb_n_o,
	output logic                 flash_ce_n_o
);
	// Decoder to target strobes and returns
	logic                   bram_cyc;
	logic                   bram_stb;
	logic                   bram_ack;
	logic [WB_DAT_W-1:0]    bram_dat;
	logic                   sram_cyc;
	logic                   sram_stb;
	logic                   sram_ack;
	logic [WB_DAT_W-1:0]    sram_dat;
	logic                   flash_cyc;
	logic                   flash_stb;
	logic                   flash_ack;
	logic [WB_DAT_W-1:0]    flash_dat;
	// Controller pin sides
	logic [SRAM_ADR_W-1:0]  sram_adr;
	logic [MEM_DAT_W-1:0]   sram_d;
	logic                   sram_d_oe;
	logic                   sram_oe_n;
	logic                   sram_we_n;
	logic [1:0]             sram_be_n;
	logic [FLASH_ADR_W-1:0] flash_adr;
	logic                   flash_oe_n;

	// --------------------------------------------------
	// Bus side
	// --------------------------------------------------
	wb_addr_decode u_decode (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_adr_i    (wb_adr_i),
		.bram_dat_i  (bram_dat),
		.sram_dat_i  (sram_dat),
		.flash_dat_i (flash_dat),
		.bram_ack_i  (bram_ack),
		.sram_ack_i  (sram_ack),
		.flash_ack_i (flash_ack),
		.bram_cyc_o  (bram_cyc),
		.bram_stb_o  (bram_stb),
		.sram_cyc_o  (sram_cyc),
		.sram_stb_o  (sram_stb),
		.flash_cyc_o (flash_cyc),
		.flash_stb_o (flash_stb),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o)
	);

	wb_bram u_bram (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.cyc_i   (bram_cyc),
		.stb_i   (bram_stb),
		.we_i    (wb_we_i),
		.adr_i   (wb_adr_i[BRAM_ADR_W-1:0]),
		.sel_i   (wb_sel_i),
		.dat_i   (wb_dat_i),
		.dat_o   (bram_dat),
		.ack_o   (bram_ack)
	);

	// --------------------------------------------------
	// External memory controllers
	// --------------------------------------------------
	wb_sram16 u_sram (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.cyc_i       (sram_cyc),
		.stb_i       (sram_stb),
		.we_i        (wb_we_i),
		.adr_i       (wb_adr_i),
		.sel_i       (wb_sel_i),
		.dat_i       (wb_dat_i),
		.mem_d_i     (mem_d_i),
		.dat_o       (sram_dat),
		.ack_o       (sram_ack),
		.sram_adr_o  (sram_adr),
		.sram_d_o    (sram_d),
		.sram_d_oe_o (sram_d_oe),
		.sram_oe_n_o (sram_oe_n),
		.sram_we_n_o (sram_we_n),
		.sram_be_n_o (sram_be_n),
		.sram_ce_n_o (sram_ce_n_o)
	);

	norflash16 u_flash (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.cyc_i        (flash_cyc),
		.stb_i        (flash_stb),
		.we_i         (wb_we_i),
		.adr_i        (wb_adr_i),
		.mem_d_i      (mem_d_i),
		.dat_o        (flash_dat),
		.ack_o        (flash_ack),
		.flash_adr_o  (flash_adr),
		.flash_oe_n_o (flash_oe_n),
		.flash_ce_n_o (flash_ce_n_o)
	);

	// Shared board pins
	mem_pin_select u_pins (
		.sram_adr_i   (sram_adr),
		.sram_d_i     (sram_d),
		.sram_d_oe_i  (sram_d_oe),
		.sram_oe_n_i  (sram_oe_n),
		.sram_we_n_i  (sram_we_n),
		.sram_be_n_i  (sram_be_n),
		.sram_ce_n_i  (sram_ce_n_o),
		.flash_adr_i  (flash_adr),
		.flash_oe_n_i (flash_oe_n),
		.flash_ce_n_i (flash_ce_n_o),
		.mem_adr_o    (mem_adr_o),
		.mem_d_o      (mem_d_o),
		.mem_d_oe_o   (mem_d_oe_o),
		.mem_oe_n_o   (mem_oe_n_o),
		.mem_we_n_o   (mem_we_n_o),
		.sram_ub_n_o  (sram_ub_n_o),
		.sram_lb_n_o  (sram_lb_n_o)
	);

endmodule

// ==== verif/ext_mem_model.sv ====
`timescale 1ns/1ps
/*
 * Behavioral board SRAM and NOR flash on the shared pins, 64 halfwords each.
 * Only address bits 5:0 are decoded, so higher halfwords alias.
 * SRAM writes land on the rising clock edge; flash contents are loaded from outside.
 */
module ext_mem_model import soc_mem_pkg::*; (
	input  logic                 clk_i,
	input  logic [MEM_ADR_W-1:0] mem_adr_i,
	input  logic [MEM_DAT_W-1:0] mem_d_i,
	input  logic                 mem_d_oe_i,
	input  logic                 mem_oe_n_i,
	input  logic                 mem_we_n_i,
	input  logic                 sram_ce_n_i,
	input  logic                 sram_ub_n_i,
	input  logic                 sram_lb_n_i,
	input  logic                 flash_ce_n_i,
	output logic [MEM_DAT_W-1:0] mem_d_o
);
	localparam int HW_DEPTH = 64;

	// Halfword arrays, index is the halfword address
	logic [MEM_DAT_W-1:0] sram_mem  [HW_DEPTH];
	logic [MEM_DAT_W-1:0] flash_mem [HW_DEPTH];
	logic [5:0]           hw_adr;

	assign hw_adr = mem_adr_i[5:0];

	// SRAM write, byte lanes active low
	always @(posedge clk_i) begin
		if (!sram_ce_n_i && !mem_we_n_i && mem_d_oe_i) begin
			if (!sram_ub_n_i)
				sram_mem[hw_adr][15:8] <= mem_d_i[15:8];
			if (!sram_lb_n_i)
				sram_mem[hw_adr][7:0] <= mem_d_i[7:0];
		end
	end

	// Read data back onto the board bus, zero when nobody drives it
	always_comb begin
		if (!sram_ce_n_i && !mem_oe_n_i)
			mem_d_o = sram_mem[hw_adr];
		else if (!flash_ce_n_i && !mem_oe_n_i)
			mem_d_o = flash_mem[hw_adr];
		else
			mem_d_o = '0;
	end

endmodule

// ==== verif/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
/*
 * Random single-master traffic to block RAM, SRAM, flash and unmapped space.
 * Accesses stay in the low 32 words of each region and use a fixed seed.
 * Bytes never written are masked out of the read compares.
 */
module mem_subsystem_tb import soc_mem_pkg::*; ();
	localparam int CLK_PERIOD  = 40;
	localparam int RST_CYCLES  = 8;
	localparam int NUM_WORDS   = 32;
	localparam int BRAM_ACC    = 90;
	localparam int SRAM_ACC    = 90;
	localparam int FLASH_ACC   = 80;
	localparam int NONE_ACC    = 40;
	localparam int NUM_ACC     = BRAM_ACC + SRAM_ACC + FLASH_ACC + NONE_ACC;
	// Worst access plus the idle cycle and some margin
	localparam int ACC_CYCLES  = 2*FLASH_LATENCY + 4;
	localparam int WATCHDOG_NS = CLK_PERIOD * (RST_CYCLES + NUM_ACC * ACC_CYCLES);
	localparam logic [31:0] SEED       = 32'hf3d6_641e;
	localparam logic [31:0] SRAM_BASE  = {SRAM_REGION, 29'h0};
	localparam logic [31:0] FLASH_BASE = {FLASH_REGION, 29'h0};

	logic                 clk;
	logic                 rst_n;
	logic                 wb_cyc;
	logic                 wb_stb;
	logic                 wb_we;
	logic [WB_ADR_W-1:0]  wb_adr;
	logic [WB_SEL_W-1:0]  wb_sel;
	logic [WB_DAT_W-1:0]  wb_wdat;
	logic [WB_DAT_W-1:0]  wb_rdat;
	logic                 wb_ack;
	logic [MEM_ADR_W-1:0] mem_adr;
	logic [MEM_DAT_W-1:0] mem_din;
	logic [MEM_DAT_W-1:0] mem_dout;
	logic                 mem_d_oe;
	logic                 mem_oe_n;
	logic                 mem_we_n;
	logic                 sram_ce_n;
	logic                 sram_ub_n;
	logic                 sram_lb_n;
	logic                 flash_ce_n;
	// Halfword 2W of the word held on the bus
	logic [MEM_ADR_W-1:0] hw_pair;

	// Reference word images and per-word written lanes
	logic [WB_DAT_W-1:0]  bram_img   [NUM_WORDS];
	logic [3:0]           bram_known [NUM_WORDS];
	logic [WB_DAT_W-1:0]  sram_img   [NUM_WORDS];
	logic [3:0]           sram_known [NUM_WORDS];
	logic [WB_DAT_W-1:0]  flash_img  [NUM_WORDS];

	int errors        = 0;
	int checks        = 0;
	int pin_errors    = 0;
	int pin_checks    = 0;
	int ce_low_cycles = 0;

	mem_subsystem DUT (
		.clk_i        (clk),
		.rst_n_i      (rst_n),
		.wb_cyc_i     (wb_cyc),
		.wb_stb_i     (wb_stb),
		.wb_we_i      (wb_we),
		.wb_adr_i     (wb_adr),
		.wb_sel_i     (wb_sel),
		.wb_dat_i     (wb_wdat),
		.wb_dat_o     (wb_rdat),
		.wb_ack_o     (wb_ack),
		.mem_adr_o    (mem_adr),
		.mem_d_i      (mem_din),
		.mem_d_o      (mem_dout),
		.mem_d_oe_o   (mem_d_oe),
		.mem_oe_n_o   (mem_oe_n),
		.mem_we_n_o   (mem_we_n),
		.sram_ce_n_o  (sram_ce_n),
		.sram_ub_n_o  (sram_ub_n),
		.sram_lb_n_o  (sram_lb_n),
		.flash_ce_n_o (flash_ce_n)
	);

	ext_mem_model u_mem (
		.clk_i        (clk),
		.mem_adr_i    (mem_adr),
		.mem_d_i      (mem_dout),
		.mem_d_oe_i   (mem_d_oe),
		.mem_oe_n_i   (mem_oe_n),
		.mem_we_n_i   (mem_we_n),
		.sram_ce_n_i  (sram_ce_n),
		.sram_ub_n_i  (sram_ub_n),
		.sram_lb_n_i  (sram_lb_n),
		.flash_ce_n_i (flash_ce_n),
		.mem_d_o      (mem_din)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// Word index sits in bus address bits 6:2 for every access here
	assign hw_pair = MEM_ADR_W'({wb_adr[6:2], 1'b0});

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
		return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
	endfunction

	// Selected bytes replaced and the rest kept
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_d,
	                                            input logic [31:0] wdat,
	                                            input logic [3:0]  sel);
		logic [31:0] m;
		m = lane_mask(sel);
		return (old_d & ~m) | (wdat & m);
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp_v,
	                          input logic [31:0] got_v);
		checks++;
		if (got_v !== exp_v) begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got_v);
		end
	endtask

	task automatic expect_cycles(input string name, input int exp_v, input int got_v);
		checks++;
		if (got_v != exp_v) begin
			errors++;
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, got_v);
		end
	endtask

	task automatic report_test(input string name, input int count, input int err0);
		$display("test %s done: %0d accesses, %0d errors", name, count, errors - err0);
	endtask

	// One classic cycle from falling edge to falling edge
	task automatic do_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
	                         input logic [31:0] wdat, output logic [31:0] rdat,
	                         output int cycles);
		cycles  = 0;
		wb_we   = we;
		wb_adr  = adr;
		wb_sel  = sel;
		wb_wdat = wdat;
		wb_cyc  = 1'b1;
		wb_stb  = 1'b1;
		// Each pass covers one rising edge
		do begin
			@(negedge clk);
			cycles++;
		end while (!wb_ack && cycles < ACC_CYCLES);
		if (!wb_ack) begin
			errors++;
			$display("ERROR: no acknowledge for address %h after %0d cycles", adr, cycles);
		end
		rdat   = wb_rdat;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		// Stb stays low for one idle cycle after the ack
		@(negedge clk);
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic ram_traffic(input bit to_sram, input int count);
		int          err0;
		int          cyc;
		logic [4:0]  w;
		logic        we;
		logic [3:0]  sel;
		logic [3:0]  known;
		logic [31:0] wdat;
		logic [31:0] rdat;
		logic [31:0] expv;
		logic [31:0] m;
		err0 = errors;
		for (int n = 0; n < count; n++) begin
			w     = 5'($urandom);
			sel   = 4'($urandom_range(15, 1));
			wdat  = $urandom;
			known = to_sram ? sram_known[w] : bram_known[w];
			expv  = to_sram ? sram_img[w] : bram_img[w];
			// Untouched words get written first
			we    = ($urandom_range(1) == 1) || (known == 4'h0);
			do_access(we, (to_sram ? SRAM_BASE : 32'h0) | (32'(w) << 2), sel, wdat, rdat, cyc);
			expect_cycles(to_sram ? "sram ack latency" : "bram ack latency",
			              to_sram ? 2*SRAM_LATENCY + 1 : 1, cyc);
			if (we) begin
				expv  = merge_bytes(expv, wdat, sel);
				known = known | sel;
				if (to_sram) begin
					sram_img[w]   = expv;
					sram_known[w] = known;
				end else begin
					bram_img[w]   = expv;
					bram_known[w] = known;
				end
			end
			m = lane_mask(known);
			if (!we)
				check_word("wb_dat_o", expv & m, rdat & m);
			// Board halfword 2W holds the high half and 2W+1 the low half
			if (to_sram && we) begin
				check_word("sram halfword 2W", {16'h0, expv[31:16] & m[31:16]},
				           {16'h0, u_mem.sram_mem[{w, 1'b0}] & m[31:16]});
				check_word("sram halfword 2W+1", {16'h0, expv[15:0] & m[15:0]},
				           {16'h0, u_mem.sram_mem[{w, 1'b1}] & m[15:0]});
			end
		end
		report_test(to_sram ? "sram" : "block ram", count, err0);
	endtask

	task automatic flash_traffic(input int count);
		int          err0;
		int          cyc;
		int          ce0;
		int          n;
		logic [4:0]  w;
		logic [31:0] rdat;
		err0 = errors;
		n    = 0;
		while (n < count) begin
			w = 5'($urandom);
			// Some reads follow a write that must be ignored
			if (n < count - 1 && $urandom_range(3) == 0) begin
				ce0 = ce_low_cycles;
				do_access(1'b1, FLASH_BASE | (32'(w) << 2), 4'hf, $urandom, rdat, cyc);
				expect_cycles("flash write ack latency", 1, cyc);
				// Program cycles never reach the board pins
				checks++;
				if (ce_low_cycles != ce0) begin
					errors++;
					$display("ERROR: flash write to address %h selected a board part",
					         FLASH_BASE | (32'(w) << 2));
				end
				n++;
			end
			do_access(1'b0, FLASH_BASE | (32'(w) << 2), 4'hf, 32'h0, rdat, cyc);
			expect_cycles("flash read ack latency", 2*FLASH_LATENCY + 1, cyc);
			check_word("wb_dat_o", flash_img[w], rdat);
			n++;
		end
		report_test("flash", count, err0);
	endtask

	task automatic unmapped_traffic(input int count);
		int          err0;
		int          cyc;
		int          ce0;
		logic [2:0]  hole;
		logic [31:0] adr;
		logic [31:0] rdat;
		err0 = errors;
		for (int n = 0; n < count; n++) begin
			hole = 3'($urandom);
			// Region 0 above the block RAM or a free top region
			if (hole == 3'h0 || hole == SRAM_REGION || hole == FLASH_REGION)
				adr = 32'h0002_0000 | ($urandom & 32'h0001_fffc);
			else
				adr = {hole, 29'($urandom)};
			ce0 = ce_low_cycles;
			do_access(1'($urandom), adr, 4'hf, $urandom, rdat, cyc);
			expect_cycles("unmapped ack latency", 1, cyc);
			check_word("wb_dat_o", 32'h0, rdat);
			checks++;
			if (ce_low_cycles != ce0) begin
				errors++;
				$display("ERROR: a chip enable went low for unmapped address %h", adr);
			end
		end
		report_test("unmapped", count, err0);
	endtask

	// --------------------------------------------------
	// Pin sharing monitor on settled pins
	// --------------------------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			pin_checks++;
			if (!sram_ce_n && !flash_ce_n) begin
				pin_errors++;
				$display("ERROR: %0t SRAM and flash chip enables low together", $time);
			end
			if (mem_d_oe && !(!sram_ce_n && !mem_we_n)) begin
				pin_errors++;
				$display("ERROR: %0t data driven outside an SRAM write", $time);
			end
			// Selected part sees halfword 2W or 2W+1, idle pins show zero
			if (!sram_ce_n || !flash_ce_n) begin
				ce_low_cycles++;
				if (mem_adr !== hw_pair && mem_adr !== {hw_pair[MEM_ADR_W-1:1], 1'b1}) begin
					pin_errors++;
					$display("[FAIL] %0t mem_adr_o expected %h or %h got %h", $time,
					         hw_pair, {hw_pair[MEM_ADR_W-1:1], 1'b1}, mem_adr);
				end
			end else if (mem_adr !== MEM_ADR_W'(0)) begin
				pin_errors++;
				$display("[FAIL] %0t mem_adr_o expected %h got %h", $time,
				         MEM_ADR_W'(0), mem_adr);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired at %0t, bus traffic stalled", $time);
		$display("Simulation failed");
		$finish;
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		logic [4:0]  w;
		logic [15:0] hi;
		logic [15:0] lo;
		int          err0;
		int          total_err;
		clk     = 1'b0;
		rst_n   = 1'b0;
		wb_cyc  = 1'b0;
		wb_stb  = 1'b0;
		wb_we   = 1'b0;
		wb_adr  = '0;
		wb_sel  = '0;
		wb_wdat = '0;
		bram_known = '{default: '0};
		sram_known = '{default: '0};
		bram_img   = '{default: '0};
		sram_img   = '{default: '0};
		void'($urandom(SEED));
		// Flash preload mirrored into the word image
		for (int i = 0; i < NUM_WORDS; i++) begin
			w  = 5'(i);
			hi = 16'($urandom);
			lo = 16'($urandom);
			flash_img[w]               = {hi, lo};
			u_mem.flash_mem[{w, 1'b0}] = hi;
			u_mem.flash_mem[{w, 1'b1}] = lo;
		end
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		err0 = errors;
		check_word("wb_ack_o", 32'h0, 32'(wb_ack));
		check_word("sram_ce_n_o", 32'h1, 32'(sram_ce_n));
		check_word("flash_ce_n_o", 32'h1, 32'(flash_ce_n));
		check_word("mem_oe_n_o", 32'h1, 32'(mem_oe_n));
		check_word("mem_we_n_o", 32'h1, 32'(mem_we_n));
		check_word("mem_d_oe_o", 32'h0, 32'(mem_d_oe));
		report_test("reset state", 0, err0);

		ram_traffic(1'b0, BRAM_ACC);
		ram_traffic(1'b1, SRAM_ACC);
		flash_traffic(FLASH_ACC);
		unmapped_traffic(NONE_ACC);
		$display("test pin sharing done: %0d cycles, %0d errors", pin_checks, pin_errors);

		total_err = errors + pin_errors;
		$display("summary: %0d checks, %0d errors", checks + pin_checks, total_err);
		if (total_err == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== mem_subsystem.f ====
design/soc_mem_pkg.sv
design/wb_addr_decode.sv
design/wb_bram.sv
design/wb_sram16.sv
design/norflash16.sv
design/mem_pin_select.sv
design/mem_subsystem.sv
verif/ext_mem_model.sv
verif/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f mem_subsystem.f --top-module mem_subsystem_tb \
	&& ./obj_dir/Vmem_subsystem_tb > sim.log 2>&1 \
	|| echo "build or run reported an error"

cat sim.log 2>/dev/null

grep -q "Simulation completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
